// File: common/fetch_consts.svh
/*
 * Fetch stage constants
 * Thread count, widths, reset PC, exception vector, return opcode
 */

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

`define NUM_TRD     8               // Hardware threads
`define TRD_W       3               // Thread index width
`define PC_W        32              // PC and instruction width

`define RESET_PC    32'h0000_0100   // Thread 0 start address
`define EXC_VECTOR  32'h0000_0040   // Jump here enters exception mode

`define OP_RET      6'h2a           // Return opcode in bits 31:26

`endif

// File: common/fetch_pkg.sv
/*
 * Fetch stage types
 * Thread, PC, command, redirect, status and child map
 */

`include "fetch_consts.svh"

package fetch_pkg;

    typedef logic [`TRD_W-1:0]   trd_t;        // Thread index
    typedef logic [`PC_W-1:0]    pc_t;         // Program counter
    typedef logic [`NUM_TRD-1:0] trd_mask_t;   // One bit per thread

    // Thread command from execute
    typedef struct packed {
        logic kill;                            // Kill object thread
        logic slp;                             // Put object thread to sleep
        logic wake;                            // Wake object thread
        logic init;                            // Create a child thread
        trd_t act_trd;                         // Thread issuing the command
        trd_t obj_trd;                         // Thread being acted on
        pc_t  init_pc;                         // Start PC of a new thread
    } thread_cmd_t;

    // PC redirect for jumps and cache misses
    typedef struct packed {
        logic vld;
        trd_t trd;
        pc_t  pc;
    } redirect_t;

    // Thread table status
    typedef struct packed {
        trd_mask_t valid;                      // Allocated threads
        trd_mask_t run;                        // Threads not sleeping
        trd_t      new_trd;                    // Last created thread
        logic      full;                       // No free slot left
        logic      overflow;                   // Init with all slots taken
        logic      invalid_op;                 // Command on a non-child
    } trd_status_t;

    // Row p lists the children of thread p
    typedef trd_mask_t [`NUM_TRD-1:0] child_map_t;

endpackage

// File: insfetch/thread_ctrl.sv
/*
 * Thread table with valid and run masks, child map,
 * command checking and round-robin thread scheduler
 */

`timescale 1ns/1ps

`include "fetch_consts.svh"

module thread_ctrl import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  thread_cmd_t i_cmd,
    input  logic        i_atomic,       // Stay on the current thread
    input  trd_mask_t   i_miss_mask,    // Threads to skip on this pick

    output trd_t        o_cur_trd,
    output trd_mask_t   o_pc_wr,        // Load start PC for a new thread
    output trd_status_t o_status,
    output child_map_t  o_child
);

    trd_mask_t  valid_q, valid_d;
    trd_mask_t  run_q, run_d;
    child_map_t child_q, child_d;
    trd_t       new_q, new_d;
    logic       ovf_q, ovf_d;
    logic       inv_q, inv_d;
    trd_t       cur_q, nxt_trd;

    trd_t       free_slot;
    logic       has_free;
    trd_mask_t  obj_bit;
    logic       owned;
    logic       last_valid;
    logic       allowed;
    trd_t       cand;
    logic       found;

    assign has_free   = ~&valid_q;
    assign obj_bit    = trd_mask_t'(1) << i_cmd.obj_trd;
    assign owned      = (i_cmd.obj_trd == i_cmd.act_trd) || child_q[i_cmd.act_trd][i_cmd.obj_trd];
    assign last_valid = (valid_q & ~obj_bit) == '0;
    // Killing the last live thread would leave nothing to fetch
    assign allowed    = owned && !(i_cmd.kill && last_valid);

    // Lowest free slot, scanned downward so the lowest one wins
    always_comb begin
        free_slot = '0;
        for (int i = `NUM_TRD - 1; i >= 0; i--) begin
            if (!valid_q[i])
                free_slot = trd_t'(i);
        end
    end

    // Command execution
    always_comb begin
        valid_d = valid_q;
        run_d   = run_q;
        child_d = child_q;
        new_d   = new_q;
        ovf_d   = 1'b0;
        inv_d   = 1'b0;
        o_pc_wr = '0;
        if (i_cmd.init) begin
            if (has_free) begin
                valid_d[free_slot]                 = 1'b1;
                run_d[free_slot]                   = 1'b1;
                child_d[i_cmd.act_trd][free_slot]  = 1'b1;   // Record ownership
                o_pc_wr[free_slot]                 = 1'b1;
                new_d                              = free_slot;
            end else begin
                ovf_d = 1'b1;
            end
        end else if (i_cmd.kill || i_cmd.slp || i_cmd.wake) begin
            if (!allowed) begin
                inv_d = 1'b1;
            end else if (i_cmd.kill) begin
                valid_d[i_cmd.obj_trd] = 1'b0;
                run_d[i_cmd.obj_trd]   = 1'b0;
                child_d[i_cmd.obj_trd] = '0;                 // Drop its own children
                for (int p = 0; p < `NUM_TRD; p++)
                    child_d[p][i_cmd.obj_trd] = 1'b0;        // Remove from parent row
            end else if (i_cmd.slp) begin
                run_d[i_cmd.obj_trd] = 1'b0;
            end else begin
                run_d[i_cmd.obj_trd] = 1'b1;
            end
        end
    end

    // Round-robin pick, offset NUM_TRD wraps back to the current thread
    always_comb begin
        nxt_trd = cur_q;
        found   = 1'b0;
        cand    = cur_q;
        for (int k = 1; k <= `NUM_TRD; k++) begin
            cand = cur_q + trd_t'(k);
            if (!found && run_q[cand] && !i_miss_mask[cand]) begin
                nxt_trd = cand;
                found   = 1'b1;
            end
        end
        if (i_atomic)
            nxt_trd = cur_q;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= trd_mask_t'(1);                       // Thread 0 only
            run_q   <= trd_mask_t'(1);
            child_q <= '0;
            new_q   <= '0;
            ovf_q   <= 1'b0;
            inv_q   <= 1'b0;
            cur_q   <= '0;
        end else begin
            valid_q <= valid_d;
            run_q   <= run_d;
            child_q <= child_d;
            new_q   <= new_d;
            ovf_q   <= ovf_d;
            inv_q   <= inv_d;
            cur_q   <= nxt_trd;
        end
    end

    assign o_cur_trd = cur_q;
    assign o_child   = child_q;

    always_comb begin
        o_status.valid      = valid_q;
        o_status.run        = run_q;
        o_status.new_trd    = new_q;
        o_status.full       = &valid_q;
        o_status.overflow   = ovf_q;
        o_status.invalid_op = inv_q;
    end

endmodule

// File: insfetch/pc_sel.sv
/*
 * Per-thread PC registers with increment, jump and miss rollback
 * Exception entry and return detection
 */

`timescale 1ns/1ps

`include "fetch_consts.svh"

module pc_sel import fetch_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,

    input  trd_t      i_cur_trd,
    input  trd_mask_t i_pc_wr,          // New thread slots
    input  pc_t       i_init_pc,
    input  redirect_t i_jmp,
    input  redirect_t i_i_miss,
    input  redirect_t i_d_miss,
    input  logic      i_exp_mode,
    input  pc_t       i_i_data,

    output pc_t       o_cur_pc,
    output logic      o_jmp_exp,        // Jump into the exception vector
    output logic      o_return_op       // Return fetched in exception mode
);

    localparam pc_t PC_INC = pc_t'(4);

    pc_t pc_q [`NUM_TRD];

    logic [5:0] opcode;

    assign opcode      = i_i_data[31:26];
    assign o_cur_pc    = pc_q[i_cur_trd];
    assign o_jmp_exp   = i_jmp.vld && (i_jmp.pc == `EXC_VECTOR);
    assign o_return_op = i_exp_mode && (opcode == `OP_RET);

    // Data miss beats instruction miss beats jump beats increment
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_TRD; i++)
                pc_q[i] <= '0;
            pc_q[0] <= `RESET_PC;
        end else begin
            for (int i = 0; i < `NUM_TRD; i++) begin
                if (i_pc_wr[i]) begin
                    pc_q[i] <= i_init_pc;                   // Slot was free until now
                end else if (i_d_miss.vld && i_d_miss.trd == trd_t'(i)) begin
                    pc_q[i] <= i_d_miss.pc;
                end else if (i_i_miss.vld && i_i_miss.trd == trd_t'(i)) begin
                    pc_q[i] <= i_i_miss.pc;
                end else if (i_jmp.vld && i_jmp.trd == trd_t'(i)) begin
                    pc_q[i] <= i_jmp.pc;
                end else if (i_cur_trd == trd_t'(i)) begin
                    pc_q[i] <= pc_q[i] + PC_INC;            // Sequential fetch
                end
            end
        end
    end

endmodule

// File: insfetch/insfetch.sv
/*
 * Instruction fetch stage top level
 * Exception mode, decode pipeline register, scheduler and PC instances
 */

`timescale 1ns/1ps

module insfetch import fetch_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  thread_cmd_t i_cmd,          // Thread command from execute
    input  redirect_t   i_jmp,          // Jump
    input  redirect_t   i_d_miss,       // Data cache miss
    input  logic        i_i_miss,       // Miss on the word now in decode
    input  pc_t         i_i_data,       // Fetched instruction

    output pc_t         o_i_addr,
    output logic        o_i_rd,
    output pc_t         o_pc_dec,
    output trd_t        o_trd_dec,
    output trd_status_t o_status,
    output child_map_t  o_child
);

    logic      exp_mode;
    logic      jmp_exp;
    logic      return_op;
    logic      atomic;
    trd_t      cur_trd;
    pc_t       cur_pc;
    trd_mask_t pc_wr;
    trd_mask_t miss_mask;
    redirect_t i_miss_rd;

    assign atomic   = i_i_data[0] | exp_mode;   // Hold the scheduler on this thread
    assign o_i_addr = cur_pc;
    assign o_i_rd   = o_status.run[cur_trd];

    // Instruction miss rolls back the thread sitting in decode
    always_comb begin
        i_miss_rd.vld = i_i_miss;
        i_miss_rd.trd = o_trd_dec;
        i_miss_rd.pc  = o_pc_dec;
    end

    // Missing threads are skipped on the next pick
    always_comb begin
        miss_mask = '0;
        if (i_i_miss)
            miss_mask[o_trd_dec] = 1'b1;
        if (i_d_miss.vld)
            miss_mask[i_d_miss.trd] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exp_mode <= 1'b0;
        end else if (jmp_exp) begin
            exp_mode <= 1'b1;                   // Entry wins over exit
        end else if (return_op) begin
            exp_mode <= 1'b0;
        end
    end

    thread_ctrl u_thread_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cmd       (i_cmd),
        .i_atomic    (atomic),
        .i_miss_mask (miss_mask),
        .o_cur_trd   (cur_trd),
        .o_pc_wr     (pc_wr),
        .o_status    (o_status),
        .o_child     (o_child)
    );

    pc_sel u_pc_sel (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_cur_trd   (cur_trd),
        .i_pc_wr     (pc_wr),
        .i_init_pc   (i_cmd.init_pc),
        .i_jmp       (i_jmp),
        .i_i_miss    (i_miss_rd),
        .i_d_miss    (i_d_miss),
        .i_exp_mode  (exp_mode),
        .i_i_data    (i_i_data),
        .o_cur_pc    (cur_pc),
        .o_jmp_exp   (jmp_exp),
        .o_return_op (return_op)
    );

    // Fetch to decode pipeline register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_trd_dec <= '0;
            o_pc_dec  <= '0;
        end else begin
            o_trd_dec <= cur_trd;
            o_pc_dec  <= cur_pc;
        end
    end

endmodule

// File: test/insfetch_props.sv
/*
 * Concurrent checks on the fetch stage status and read strobe
 */

`timescale 1ns/1ps

module insfetch_props import fetch_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        i_rd,
    input trd_t        i_cur_trd,
    input trd_status_t i_status
);

    // A running thread must also be allocated
    a_rd_running: assert property (@(posedge clk) disable iff (!rst_n)
        i_rd |-> i_status.valid[i_cur_trd])
        else $error("fetch read from a thread that is not allocated");

    // Status pulses last a single cycle
    a_ovf_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i_status.overflow |=> !i_status.overflow)
        else $error("overflow held longer than one cycle");

    a_inv_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        i_status.invalid_op |=> !i_status.invalid_op)
        else $error("invalid_op held longer than one cycle");

    a_valid_live: assert property (@(posedge clk) disable iff (!rst_n)
        i_status.valid != '0)
        else $error("no valid thread left");

endmodule

bind insfetch insfetch_props u_props (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_rd      (o_i_rd),
    .i_cur_trd (cur_trd),
    .i_status  (o_status)
);

// File: test/insfetch_tb.sv
/*
 * Fetch stage testbench with instruction store, stimulus table
 * and a reference model of the PCs and round-robin order
 */

`timescale 1ns/1ps

`include "fetch_consts.svh"

module insfetch_tb import fetch_pkg::*; ();

    localparam redirect_t NO_RD   = '0;
    localparam int        RET_IDX = (`EXC_VECTOR >> 2) + 2;    // Return two words after vector

    // Op bits are kill, slp, wake, init
    typedef struct packed {
        thread_cmd_t cmd;
        redirect_t   jmp;
        redirect_t   dm;
        logic        im;
        trd_mask_t   v;             // Expected valid mask
        trd_mask_t   r;             // Expected run mask
        trd_t        nt;
        logic        ovf;
        logic        inv;
        trd_mask_t   c0;            // Expected children of thread 0
    } row_t;

    logic        clk;
    logic        rst_n;
    thread_cmd_t i_cmd;
    redirect_t   i_jmp;
    redirect_t   i_d_miss;
    logic        i_i_miss;
    pc_t         i_i_data;
    pc_t         o_i_addr;
    logic        o_i_rd;
    pc_t         o_pc_dec;
    trd_t        o_trd_dec;
    trd_status_t o_status;
    child_map_t  o_child;

    pc_t       imem [256];
    row_t      rows [$];
    row_t      rw;
    pc_t       m_pc [`NUM_TRD];     // Reference PCs
    trd_t      m_cur;
    trd_t      m_trd_dec;
    pc_t       m_pc_dec;
    trd_mask_t m_run;
    logic      m_exp;
    int        errors;
    int        row_err;
    int        checks;
    int        cycles;
    int        limit;

    insfetch uut (.*);

    assign i_i_data = imem[o_i_addr[9:2]];     // Combinational instruction store

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: no result after %0d cycles", limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
            row_err++;
        end
    endtask

    task automatic add_row(input logic [3:0] op, input trd_t act, input trd_t obj,
                           input pc_t ipc, input redirect_t jmp, input redirect_t dm,
                           input logic im, input trd_mask_t v, input trd_mask_t r,
                           input trd_t nt, input logic ovf, input logic inv,
                           input trd_mask_t c0);
        rows.push_back({op, act, obj, ipc, jmp, dm, im, v, r, nt, ovf, inv, c0});
    endtask

    task automatic idle(input int n, input trd_mask_t v, input trd_mask_t r,
                        input trd_t nt, input trd_mask_t c0);
        repeat (n) add_row(4'b0000, 3'd0, 3'd0, '0, NO_RD, NO_RD, 1'b0, v, r, nt, 1'b0, 1'b0, c0);
    endtask

    task automatic build_table();
        trd_mask_t m;
        idle(4, 8'h01, 8'h01, 3'd0, 8'h00);
        // Thread 0 fills slots 1 to 7 in order
        for (int s = 1; s < `NUM_TRD; s++) begin
            m = trd_mask_t'((1 << (s + 1)) - 1);
            add_row(4'b0001, 3'd0, 3'd0, pc_t'(32'h100 + 32'h40 * s), NO_RD, NO_RD, 1'b0,
                    m, m, trd_t'(s), 1'b0, 1'b0, m ^ 8'h01);
        end
        add_row(4'b0001, 3'd0, 3'd0, 32'h3f0, NO_RD, NO_RD, 1'b0, 8'hff, 8'hff, 3'd7, 1'b1, 1'b0, 8'hfe);
        idle(10, 8'hff, 8'hff, 3'd7, 8'hfe);
        add_row(4'b0100, 3'd0, 3'd3, '0, NO_RD, NO_RD, 1'b0, 8'hff, 8'hf7, 3'd7, 1'b0, 1'b0, 8'hfe);
        idle(3, 8'hff, 8'hf7, 3'd7, 8'hfe);
        add_row(4'b0010, 3'd0, 3'd3, '0, NO_RD, NO_RD, 1'b0, 8'hff, 8'hff, 3'd7, 1'b0, 1'b0, 8'hfe);
        add_row(4'b1000, 3'd0, 3'd2, '0, NO_RD, NO_RD, 1'b0, 8'hfb, 8'hfb, 3'd7, 1'b0, 1'b0, 8'hfa);
        add_row(4'b1000, 3'd3, 3'd5, '0, NO_RD, NO_RD, 1'b0, 8'hfb, 8'hfb, 3'd7, 1'b0, 1'b1, 8'hfa);
        idle(1, 8'hfb, 8'hfb, 3'd7, 8'hfa);
        add_row(4'b0100, 3'd4, 3'd6, '0, NO_RD, NO_RD, 1'b0, 8'hfb, 8'hfb, 3'd7, 1'b0, 1'b1, 8'hfa);
        idle(2, 8'hfb, 8'hfb, 3'd7, 8'hfa);
        add_row(4'b0001, 3'd0, 3'd0, 32'h280, NO_RD, NO_RD, 1'b0, 8'hff, 8'hff, 3'd2, 1'b0, 1'b0, 8'hfe);
        idle(4, 8'hff, 8'hff, 3'd2, 8'hfe);
        add_row(4'b0000, 3'd0, 3'd0, '0, {1'b1, 3'd5, 32'h300}, NO_RD, 1'b0,
                8'hff, 8'hff, 3'd2, 1'b0, 1'b0, 8'hfe);
        add_row(4'b0000, 3'd0, 3'd0, '0, NO_RD, {1'b1, 3'd0, 32'h3a0}, 1'b1,
                8'hff, 8'hff, 3'd2, 1'b0, 1'b0, 8'hfe);
        idle(2, 8'hff, 8'hff, 3'd2, 8'hfe);
        add_row(4'b0000, 3'd0, 3'd0, '0, NO_RD, NO_RD, 1'b1, 8'hff, 8'hff, 3'd2, 1'b0, 1'b0, 8'hfe);
        add_row(4'b0000, 3'd0, 3'd0, '0, NO_RD, {1'b1, 3'd6, 32'h380}, 1'b0,
                8'hff, 8'hff, 3'd2, 1'b0, 1'b0, 8'hfe);
        idle(10, 8'hff, 8'hff, 3'd2, 8'hfe);
        add_row(4'b0000, 3'd0, 3'd0, '0, {1'b1, 3'd0, `EXC_VECTOR}, NO_RD, 1'b0,
                8'hff, 8'hff, 3'd2, 1'b0, 1'b0, 8'hfe);
        idle(10, 8'hff, 8'hff, 3'd2, 8'hfe);
    endtask

    // Advance the reference model by one rising edge
    task automatic step_model();
        pc_t       data;
        pc_t       cur_pc;
        trd_mask_t miss;
        trd_t      nxt;
        trd_t      c;
        data   = imem[m_pc[m_cur][9:2]];
        cur_pc = m_pc[m_cur];
        miss   = '0;
        if (rw.im && rw.dm.vld)
            rw.dm.trd = m_trd_dec;                  // Both misses on the decode thread
        if (rw.im)
            miss[m_trd_dec] = 1'b1;
        if (rw.dm.vld)
            miss[rw.dm.trd] = 1'b1;
        nxt = m_cur;
        if (!m_exp) begin                           // Store words have bit 0 clear
            for (int k = `NUM_TRD; k >= 1; k--) begin
                c = m_cur + trd_t'(k);
                if (m_run[c] && !miss[c])
                    nxt = c;                        // Nearest offset wins
            end
        end
        if (rw.jmp.vld && rw.jmp.pc == `EXC_VECTOR)
            rw.jmp.trd = nxt;                       // Vector jump on the thread picked next
        for (int i = 0; i < `NUM_TRD; i++) begin
            if (rw.cmd.init && !rw.ovf && rw.nt == trd_t'(i))
                m_pc[i] = rw.cmd.init_pc;
            else if (rw.dm.vld && rw.dm.trd == trd_t'(i))
                m_pc[i] = rw.dm.pc;
            else if (rw.im && m_trd_dec == trd_t'(i))
                m_pc[i] = m_pc_dec;
            else if (rw.jmp.vld && rw.jmp.trd == trd_t'(i))
                m_pc[i] = rw.jmp.pc;
            else if (m_cur == trd_t'(i))
                m_pc[i] = m_pc[i] + 32'd4;
        end
        if (rw.jmp.vld && rw.jmp.pc == `EXC_VECTOR)
            m_exp = 1'b1;
        else if (m_exp && data[31:26] == `OP_RET)
            m_exp = 1'b0;
        m_trd_dec = m_cur;
        m_pc_dec  = cur_pc;
        m_cur     = nxt;
        m_run     = rw.r;
    endtask

    initial begin
        pc_t w;
        clk      = 1'b0;
        rst_n    = 1'b0;
        i_cmd    = '0;
        i_jmp    = '0;
        i_d_miss = '0;
        i_i_miss = 1'b0;
        errors   = 0;
        checks   = 0;
        cycles   = 0;
        limit    = 0;
        void'($urandom(32'h51c1_dd59));
        for (int a = 0; a < 256; a++) begin
            w    = $urandom();
            w[0] = 1'b0;                            // Keep the scheduler free running
            if (w[31:26] == `OP_RET)
                w[31] = ~w[31];
            imem[a] = w;
        end
        imem[RET_IDX] = {`OP_RET, 26'd0};
        for (int i = 0; i < `NUM_TRD; i++)
            m_pc[i] = '0;
        m_pc[0]   = `RESET_PC;
        m_cur     = '0;
        m_trd_dec = '0;
        m_pc_dec  = '0;
        m_run     = 8'h01;
        m_exp     = 1'b0;
        build_table();
        limit = 2 * rows.size() + 50;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        check_val("o_i_addr", o_i_addr, `RESET_PC);
        foreach (rows[n]) begin
            rw = rows[n];
            step_model();
            i_cmd    = rw.cmd;
            i_jmp    = rw.jmp;
            i_d_miss = rw.dm;
            i_i_miss = rw.im;
            @(negedge clk);
            row_err = 0;
            check_val("o_i_addr", o_i_addr, m_pc[m_cur]);
            check_val("o_i_rd", 32'(o_i_rd), 32'(rw.r[m_cur]));
            check_val("o_trd_dec", 32'(o_trd_dec), 32'(m_trd_dec));
            check_val("o_pc_dec", o_pc_dec, m_pc_dec);
            check_val("valid", 32'(o_status.valid), 32'(rw.v));
            check_val("run", 32'(o_status.run), 32'(rw.r));
            check_val("new_trd", 32'(o_status.new_trd), 32'(rw.nt));
            check_val("full", 32'(o_status.full), 32'(rw.v == 8'hff));
            check_val("overflow", 32'(o_status.overflow), 32'(rw.ovf));
            check_val("invalid_op", 32'(o_status.invalid_op), 32'(rw.inv));
            check_val("o_child", o_child, {56'h0, rw.c0});   // Only thread 0 has children
            $display("row %0d done, %0d errors", n, row_err);
        end
        $display("%0d rows, %0d checks, %0d errors", rows.size(), checks, errors);
        if (errors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+common
common/fetch_pkg.sv
insfetch/thread_ctrl.sv
insfetch/pc_sel.sv
insfetch/insfetch.sv
test/insfetch_props.sv
test/insfetch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the fetch stage testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module insfetch_tb -f verilog.f \
    && ./obj_dir/Vinsfetch_tb > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "RESULT: PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
